// File: verilog/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address of word 0 of the on-chip memory
`define MEM_BASE 64'h8000_0000

// the memory holds 2**MEM_WORDS_LOG2 words of 64 bits
`define MEM_WORDS_LOG2 8

`endif

// File: verilog/mem_word_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_word_pkg;

    // index of one 64-bit word inside the memory
    typedef logic [`MEM_WORDS_LOG2-1:0] word_idx_t;

    // one memory word, seen whole or split into lanes
    // lane 0 is the least significant in both split views
    typedef union packed {
        logic [63:0]       dw;
        logic [7:0][7:0]   bytes;
        logic [3:0][15:0]  halves;
    } mem_word_u;

endpackage

`default_nettype wire

// File: verilog/load_op_pkg.sv
`default_nettype none

package load_op_pkg;

    // bit 2 selects zero extension, bits 1:0 give the access width
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } load_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE   = 2'b00,
        SZ_HALF   = 2'b01,
        SZ_WORD   = 2'b10,
        SZ_DOUBLE = 2'b11
    } load_size_e;

    function automatic load_size_e op_size(input load_op_e op);
        return load_size_e'(op[1:0]);
    endfunction

    function automatic logic op_unsigned(input load_op_e op);
        return op[2];
    endfunction

endpackage

`default_nettype wire

// File: verilog/mem_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_array (
    input  wire                      clk,
    input  wire                      wr_word_en,
    input  wire  mem_word_pkg::word_idx_t wr_idx,
    input  wire  [63:0]              wr_data,
    input  wire                      rd0_en,
    input  wire  mem_word_pkg::word_idx_t rd0_idx,
    input  wire                      rd1_en,
    input  wire  mem_word_pkg::word_idx_t rd1_idx,
    output mem_word_pkg::mem_word_u  rd0_word,
    output mem_word_pkg::mem_word_u  rd1_word
);

    localparam int DEPTH = 1 << `MEM_WORDS_LOG2;

    logic [63:0] mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_word_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // a read in the same cycle as a write to that word sees the old contents
    always_ff @(posedge clk) begin
        if (rd0_en) begin
            rd0_word.dw <= mem[rd0_idx];
        end
        if (rd1_en) begin
            rd1_word.dw <= mem[rd1_idx];
        end
    end

    a_en_known : assert property (
        @(posedge clk)
        !$isunknown({wr_word_en, rd0_en, rd1_en})
    );

    // an enabled port must also carry a known index into the array
    a_idx_known : assert property (
        @(posedge clk)
        (rd0_en || rd1_en || wr_word_en) |->
            (!rd0_en || !$isunknown(rd0_idx)) &&
            (!rd1_en || !$isunknown(rd1_idx)) &&
            (!wr_word_en || !$isunknown(wr_idx))
    );

endmodule

`default_nettype wire

// File: verilog/fetch_align.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_align (
    input  wire  mem_word_pkg::mem_word_u rd0_word,
    input  wire                           fetch_hi,
    input  wire                           fetch_error,
    output logic [31:0]                   instr
);

    // an instruction is the upper or lower pair of half lanes
    always_comb begin
        if (fetch_error) begin
            instr = '0;
        end else if (fetch_hi) begin
            instr = {rd0_word.halves[3], rd0_word.halves[2]};
        end else begin
            instr = {rd0_word.halves[1], rd0_word.halves[0]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire  mem_word_pkg::mem_word_u rd1_word,
    input  wire  [2:0]                    load_lane,
    input  wire  load_op_pkg::load_op_e   load_op_q,
    input  wire                           load_error,
    output logic [63:0]                   load_data
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic [31:0] word_val;
    logic        zext;
    logic [63:0] ext_val;

    // address bits below the access width do not take part in the lane select
    assign byte_val = rd1_word.bytes[load_lane];
    assign half_val = rd1_word.halves[load_lane[2:1]];
    assign word_val = load_lane[2] ? {rd1_word.halves[3], rd1_word.halves[2]}
                                   : {rd1_word.halves[1], rd1_word.halves[0]};

    assign zext = load_op_pkg::op_unsigned(load_op_q);

    always_comb begin
        case (load_op_pkg::op_size(load_op_q))
            load_op_pkg::SZ_BYTE: begin
                if (zext) begin
                    ext_val = {56'b0, byte_val};
                end else begin
                    ext_val = {{56{byte_val[7]}}, byte_val};
                end
            end
            load_op_pkg::SZ_HALF: begin
                if (zext) begin
                    ext_val = {48'b0, half_val};
                end else begin
                    ext_val = {{48{half_val[15]}}, half_val};
                end
            end
            load_op_pkg::SZ_WORD: begin
                if (zext) begin
                    ext_val = {32'b0, word_val};
                end else begin
                    ext_val = {{32{word_val[31]}}, word_val};
                end
            end
            default: begin
                ext_val = rd1_word.dw;
            end
        endcase
    end

    assign load_data = load_error ? 64'b0 : ext_val;

endmodule

`default_nettype wire

// File: verilog/mem_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_rd_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       fetch_en,
    input  wire  [63:0]               pc,
    input  wire                       load_en,
    input  wire  [63:0]               load_addr,
    input  wire  load_op_pkg::load_op_e load_op,
    input  wire                       wr_en,
    input  wire  [63:0]               wr_addr,
    output logic                      rd0_en,
    output mem_word_pkg::word_idx_t   rd0_idx,
    output logic                      rd1_en,
    output mem_word_pkg::word_idx_t   rd1_idx,
    output logic                      wr_word_en,
    output mem_word_pkg::word_idx_t   wr_idx,
    output logic                      fetch_hi,
    output logic [2:0]                load_lane,
    output load_op_pkg::load_op_e     load_op_q,
    output logic                      instr_valid,
    output logic                      fetch_error,
    output logic                      load_valid,
    output logic                      load_error
);

    // byte offset bits covered by the memory window
    localparam int OFS_BITS = `MEM_WORDS_LOG2 + 3;

    logic fetch_ok;
    logic load_ok;
    logic wr_ok;

    // addresses below the base wrap to a large offset and fail the check too
    function automatic logic in_window(input logic [63:0] addr);
        logic [63:0] ofs;
        ofs = addr - `MEM_BASE;
        return ofs[63:OFS_BITS] == '0;
    endfunction

    function automatic mem_word_pkg::word_idx_t to_idx(input logic [63:0] addr);
        logic [63:0] ofs;
        ofs = addr - `MEM_BASE;
        return ofs[OFS_BITS-1:3];
    endfunction

    assign fetch_ok = in_window(pc);
    assign load_ok  = in_window(load_addr);
    assign wr_ok    = in_window(wr_addr);

    assign rd0_en     = fetch_en && fetch_ok;
    assign rd0_idx    = to_idx(pc);
    assign rd1_en     = load_en && load_ok;
    assign rd1_idx    = to_idx(load_addr);
    // writes outside the window are simply dropped
    assign wr_word_en = wr_en && wr_ok;
    assign wr_idx     = to_idx(wr_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
            fetch_error <= 1'b0;
            load_valid  <= 1'b0;
            load_error  <= 1'b0;
        end else begin
            instr_valid <= fetch_en;
            fetch_error <= fetch_en && !fetch_ok;
            load_valid  <= load_en;
            load_error  <= load_en && !load_ok;
        end
    end

    // lane selects travel alongside the word that the array is reading
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_hi <= pc[2];
        end
        if (load_en) begin
            load_lane <= load_addr[2:0];
            load_op_q <= load_op;
        end
    end

    a_load_op_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        load_en |-> load_op != 3'b111
    );

endmodule

`default_nettype wire

// File: verilog/mem_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         fetch_en,
    input  wire  [63:0]                 pc,
    input  wire                         load_en,
    input  wire  [63:0]                 load_addr,
    input  wire  load_op_pkg::load_op_e load_op,
    input  wire                         wr_en,
    input  wire  [63:0]                 wr_addr,
    input  wire  [63:0]                 wr_data,
    output logic [31:0]                 instr,
    output logic                        instr_valid,
    output logic                        fetch_error,
    output logic [63:0]                 load_data,
    output logic                        load_valid,
    output logic                        load_error
);

    logic                    rd0_en;
    mem_word_pkg::word_idx_t rd0_idx;
    logic                    rd1_en;
    mem_word_pkg::word_idx_t rd1_idx;
    logic                    wr_word_en;
    mem_word_pkg::word_idx_t wr_idx;
    mem_word_pkg::mem_word_u rd0_word;
    mem_word_pkg::mem_word_u rd1_word;
    logic                    fetch_hi;
    logic [2:0]              load_lane;
    load_op_pkg::load_op_e   load_op_q;

    mem_rd_ctrl u_mem_rd_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .pc          (pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_op     (load_op),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .rd0_en      (rd0_en),
        .rd0_idx     (rd0_idx),
        .rd1_en      (rd1_en),
        .rd1_idx     (rd1_idx),
        .wr_word_en  (wr_word_en),
        .wr_idx      (wr_idx),
        .fetch_hi    (fetch_hi),
        .load_lane   (load_lane),
        .load_op_q   (load_op_q),
        .instr_valid (instr_valid),
        .fetch_error (fetch_error),
        .load_valid  (load_valid),
        .load_error  (load_error)
    );

    mem_array u_mem_array (
        .clk        (clk),
        .wr_word_en (wr_word_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .rd0_en     (rd0_en),
        .rd0_idx    (rd0_idx),
        .rd1_en     (rd1_en),
        .rd1_idx    (rd1_idx),
        .rd0_word   (rd0_word),
        .rd1_word   (rd1_word)
    );

    fetch_align u_fetch_align (
        .rd0_word    (rd0_word),
        .fetch_hi    (fetch_hi),
        .fetch_error (fetch_error),
        .instr       (instr)
    );

    load_align u_load_align (
        .rd1_word   (rd1_word),
        .load_lane  (load_lane),
        .load_op_q  (load_op_q),
        .load_error (load_error),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// File: tests/mem_rd_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_rd_tb;

    localparam int          NUM_WORDS  = 1 << `MEM_WORDS_LOG2;
    localparam logic [63:0] MEM_BYTES  = 64'(NUM_WORDS) * 8;
    localparam int          WAIT_LIMIT = 8;

    typedef struct {
        logic                  fetch_en;
        logic [63:0]           pc;
        logic                  load_en;
        load_op_pkg::load_op_e load_op;
        logic [63:0]           load_addr;
        logic [31:0]           exp_instr;
        logic                  exp_ferr;
        logic [63:0]           exp_data;
        logic                  exp_lerr;
    } vector_t;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_en;
    logic [63:0]           pc;
    logic                  load_en;
    logic [63:0]           load_addr;
    load_op_pkg::load_op_e load_op;
    logic                  wr_en;
    logic [63:0]           wr_addr;
    logic [63:0]           wr_data;
    logic [31:0]           instr;
    logic                  instr_valid;
    logic                  fetch_error;
    logic [63:0]           load_data;
    logic                  load_valid;
    logic                  load_error;

    // reference copy of the memory contents
    logic [63:0] model [0:NUM_WORDS-1];
    vector_t     vectors [$];
    logic [63:0] rng_state;
    int          n_checks;
    int          n_errors;
    int          test_checks;
    int          test_errors;

    mem_rd_top u_mem_rd_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .pc          (pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_op     (load_op),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .instr       (instr),
        .instr_valid (instr_valid),
        .fetch_error (fetch_error),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .load_error  (load_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] next_rand();
        rng_state = xorshift64(rng_state);
        return rng_state;
    endfunction

    function automatic logic in_range(input logic [63:0] addr);
        return addr >= `MEM_BASE && addr < `MEM_BASE + MEM_BYTES;
    endfunction

    function automatic int word_of(input logic [63:0] addr);
        logic [63:0] ofs;
        ofs = addr - `MEM_BASE;
        return int'(ofs >> 3);
    endfunction

    function automatic logic [31:0] fetch_ref(input logic [63:0] word, input logic hi);
        return hi ? word[63:32] : word[31:0];
    endfunction

    function automatic logic [63:0] load_ref(input logic [63:0] word, input logic [2:0] ofs,
                                             input logic [2:0] op);
        int          nbytes;
        int          lane;
        logic [63:0] mask;
        logic [63:0] val;
        nbytes = 1 << op[1:0];
        // the access is aligned down to its own width
        lane = int'(ofs) - (int'(ofs) % nbytes);
        val = word >> (lane * 8);
        if (nbytes == 8) begin
            return val;
        end
        mask = (64'd1 << (nbytes * 8)) - 64'd1;
        val = val & mask;
        if (!op[2] && val[nbytes*8-1]) begin
            val = val | ~mask;
        end
        return val;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        test_checks++;
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    task automatic add_vector(input logic f_en, input logic [63:0] f_pc, input logic l_en,
                              input load_op_pkg::load_op_e op, input logic [63:0] l_addr);
        vector_t v;
        v.fetch_en  = f_en;
        v.pc        = f_pc;
        v.load_en   = l_en;
        v.load_op   = op;
        v.load_addr = l_addr;
        v.exp_ferr  = f_en && !in_range(f_pc);
        v.exp_lerr  = l_en && !in_range(l_addr);
        v.exp_instr = '0;
        v.exp_data  = '0;
        if (f_en && in_range(f_pc)) begin
            v.exp_instr = fetch_ref(model[word_of(f_pc)], f_pc[2]);
        end
        if (l_en && in_range(l_addr)) begin
            v.exp_data = load_ref(model[word_of(l_addr)], l_addr[2:0], op);
        end
        vectors.push_back(v);
    endtask

    task automatic check_vector(input vector_t v);
        check_val("instr_valid", v.fetch_en, instr_valid);
        check_val("fetch_error", v.exp_ferr, fetch_error);
        if (v.fetch_en) begin
            check_val("instr", v.exp_instr, instr);
        end
        check_val("load_valid", v.load_en, load_valid);
        check_val("load_error", v.exp_lerr, load_error);
        if (v.load_en) begin
            check_val("load_data", v.exp_data, load_data);
        end
    endtask

    // entry i is driven at one edge and its result is checked after the next one
    task automatic apply_vectors();
        int n;
        n = vectors.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            if (i < n) begin
                fetch_en  <= vectors[i].fetch_en;
                pc        <= vectors[i].pc;
                load_en   <= vectors[i].load_en;
                load_op   <= vectors[i].load_op;
                load_addr <= vectors[i].load_addr;
            end else begin
                fetch_en <= 1'b0;
                load_en  <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_vector(vectors[i-1]);
            end
        end
        vectors.delete();
    endtask

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
        if (in_range(addr)) begin
            model[word_of(addr)] = data;
        end
    endtask

    task automatic write_then_read(input int idx, input logic [63:0] data);
        logic [63:0] addr;
        int          cycles;
        addr = `MEM_BASE + 64'(idx) * 8;
        write_word(addr, data);
        load_en   <= 1'b1;
        load_op   <= load_op_pkg::LD;
        load_addr <= addr;
        @(posedge clk);
        load_en <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (load_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (load_valid !== 1'b1) begin
            $display("timeout: load_valid never rose after reading word %0d", idx);
            n_errors++;
            test_errors++;
        end else begin
            check_val("load_latency", 0, cycles);
            check_val("load_data", data, load_data);
            check_val("load_error", 0, load_error);
        end
    endtask

    initial begin
        logic [63:0] rnd;
        logic [63:0] laddr;
        logic [2:0]  code;
        rng_state   = 64'd23324;
        n_checks    = 0;
        n_errors    = 0;
        test_checks = 0;
        test_errors = 0;
        rst_n       = 1'b0;
        // out-of-range requests stay pending through reset and only the reset keeps the flags low
        fetch_en    = 1'b1;
        pc          = '0;
        load_en     = 1'b1;
        load_addr   = '0;
        load_op     = load_op_pkg::LB;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        repeat (3) @(posedge clk);
        rst_n    <= 1'b1;
        fetch_en <= 1'b0;
        load_en  <= 1'b0;

        start_test();
        @(negedge clk);
        check_val("instr_valid", 0, instr_valid);
        check_val("load_valid", 0, load_valid);
        check_val("fetch_error", 0, fetch_error);
        check_val("load_error", 0, load_error);
        end_test("reset");

        // words 3 and 4 give every lane a set and a clear top bit
        for (int i = 0; i < NUM_WORDS; i++) begin
            if (i == 3) begin
                write_word(`MEM_BASE + 64'(i) * 8, 64'h8081_92a3_f0c1_e2d3);
            end else if (i == 4) begin
                write_word(`MEM_BASE + 64'(i) * 8, 64'h7f01_3f02_7f63_0f04);
            end else begin
                write_word(`MEM_BASE + 64'(i) * 8, next_rand());
            end
        end

        start_test();
        add_vector(1'b1, `MEM_BASE, 1'b0, load_op_pkg::LB, '0);
        add_vector(1'b1, `MEM_BASE + 4, 1'b0, load_op_pkg::LB, '0);
        add_vector(1'b1, `MEM_BASE + 40 + 2, 1'b0, load_op_pkg::LB, '0);
        add_vector(1'b1, `MEM_BASE + 40 + 7, 1'b0, load_op_pkg::LB, '0);
        add_vector(1'b1, `MEM_BASE + MEM_BYTES - 8, 1'b0, load_op_pkg::LB, '0);
        add_vector(1'b1, `MEM_BASE + MEM_BYTES - 4, 1'b0, load_op_pkg::LB, '0);
        apply_vectors();
        end_test("fetch");

        start_test();
        for (int c = 0; c < 7; c++) begin
            for (int w = 3; w <= 4; w++) begin
                for (int o = 0; o < 8; o++) begin
                    add_vector(1'b0, '0, 1'b1, load_op_pkg::load_op_e'(3'(c)),
                               `MEM_BASE + 64'(w) * 8 + 64'(o));
                end
            end
        end
        apply_vectors();
        end_test("load_ops");

        start_test();
        add_vector(1'b1, `MEM_BASE - 4, 1'b1, load_op_pkg::LD, `MEM_BASE - 8);
        add_vector(1'b1, `MEM_BASE + MEM_BYTES, 1'b1, load_op_pkg::LW, `MEM_BASE + MEM_BYTES + 4);
        add_vector(1'b1, 64'h0, 1'b1, load_op_pkg::LBU, 64'hffff_ffff_ffff_fff8);
        add_vector(1'b1, `MEM_BASE + MEM_BYTES - 4, 1'b1, load_op_pkg::LB, `MEM_BASE + MEM_BYTES);
        apply_vectors();
        write_word(`MEM_BASE - 8, 64'hdead_beef_0bad_f00d);
        write_word(`MEM_BASE + MEM_BYTES, 64'h1234_5678_9abc_def0);
        write_word(64'h0, 64'hffff_0000_ffff_0000);
        for (int i = 0; i < NUM_WORDS; i++) begin
            add_vector(1'b0, '0, 1'b1, load_op_pkg::LD, `MEM_BASE + 64'(i) * 8);
        end
        apply_vectors();
        end_test("out_of_range");

        start_test();
        for (int i = 0; i < 24; i++) begin
            rnd   = next_rand();
            code  = 3'(rnd[47:40] % 8'd7);
            laddr = `MEM_BASE + (rnd[39:16] & (MEM_BYTES - 1));
            if (rnd[59:56] == 4'h0) begin
                laddr = `MEM_BASE + MEM_BYTES + 64'(rnd[15:0]);
            end
            add_vector(rnd[63] | rnd[62], `MEM_BASE + (rnd[15:0] & (MEM_BYTES - 1)),
                       rnd[61] | rnd[60], load_op_pkg::load_op_e'(code), laddr);
        end
        apply_vectors();
        write_then_read(17, 64'hcafe_f00d_5555_aaaa);
        write_then_read(NUM_WORDS - 1, 64'h0123_4567_89ab_cdef);
        end_test("concurrent");

        $display("total %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_rd.f
+incdir+verilog
verilog/mem_word_pkg.sv
verilog/load_op_pkg.sv
verilog/mem_array.sv
verilog/fetch_align.sv
verilog/load_align.sv
verilog/mem_rd_ctrl.sv
verilog/mem_rd_top.sv
tests/mem_rd_tb.sv
